/* Makefile */
SIM  := obj_dir/Vtb_csr_unit
SRCS := csr_pkg.sv csr_perf_counters.sv csr_irq_arbiter.sv csr_file.sv csr_unit.sv \
        csr_unit_assertions.sv csr_checker.sv tb_csr_unit.sv

.PHONY: all run clean

all: run

$(SIM): $(SRCS) project.f
	verilator --binary --timing --assert --top-module tb_csr_unit -f project.f \
	    -Mdir obj_dir -o Vtb_csr_unit

run: $(SIM)
	./$(SIM) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Simulation failed" sim.log || \
	    ! grep -q "Simulation completed successfully" sim.log; then \
	    echo "Run FAILED"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

/* csr_checker.sv */
module csr_checker
    import csr_pkg::*;
(
    input  logic        clk,
    input  logic [31:0] rdata_i,
    input  logic        irq_pending_i,
    input  logic [11:0] addr_i,
    input  logic [31:0] mtvec_i,
    input  logic [31:0] mepc_i,
    input  logic [1:0]  mode_i,        // 0 none, 1 exact, 2 capture, 3 delta
    input  logic [31:0] exp_rdata_i,
    input  logic        exp_pending_i,
    input  int          row_i,
    output int          pass_count_o,
    output int          fail_count_o
);

    logic [31:0] captured;
    logic [31:0] want;
    logic        ok;

    initial begin
        pass_count_o = 0;
        fail_count_o = 0;
        captured     = '0;
    end

    // Inputs change on this edge too, but only through nonblocking updates
    always @(negedge clk) begin
        if (mode_i != 2'd0) begin
            ok   = 1'b1;
            want = (mode_i == 2'd3) ? captured + exp_rdata_i : exp_rdata_i;
            if (mode_i == 2'd2) begin
                captured = rdata_i; // Reference for a later delta row
            end else if (rdata_i != want) begin
                ok = 1'b0;
            end
            // Fetch-side outputs carry the same register contents
            if (mode_i == 2'd1 && addr_i == MTVEC && mtvec_i != want) ok = 1'b0;
            if (mode_i == 2'd1 && addr_i == MEPC && mepc_i != want) ok = 1'b0;
            if (irq_pending_i != exp_pending_i) ok = 1'b0;
            if (ok) begin
                pass_count_o = pass_count_o + 1;
                $display("[PASS] row %0d rdata %h irq_pending %b", row_i, rdata_i,
                         irq_pending_i);
            end else begin
                fail_count_o = fail_count_o + 1;
                $display(
                    "[FAIL] t=%0t row %0d rdata %h exp %h irq_pending %b exp %b mtvec %h mepc %h",
                    $time, row_i, rdata_i, want, irq_pending_i, exp_pending_i, mtvec_i,
                    mepc_i);
            end
        end
    end

endmodule

/* csr_file.sv */
module csr_file
    import csr_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    input  logic        read_en_i,
    input  logic        write_en_i,
    input  csr_op_e     op_i,
    input  logic [11:0] address_i,
    input  logic [31:0] wdata_i,
    input  logic        killed_i,
    output logic [31:0] rdata_o,

    input  logic        exception_i,
    input  logic        mret_i,
    input  exc_code_e   exc_code_i,
    input  logic [1:0]  privilege_i,
    input  logic [31:0] pc_i,
    input  logic [31:0] instr_i,

    input  logic        irq_ack_i,
    input  logic [31:0] mip_i,
    input  irq_code_e   irq_code_i,

    input  logic [63:0] cycle_i,
    input  logic [63:0] instret_i,

    output logic [31:0] mtvec_o,
    output logic [31:0] mepc_o,
    output logic [31:0] mie_o,
    output logic        mstatus_mie_o
);

    logic [31:0] mstatus_q;
    logic [31:0] misa_q;
    logic [31:0] mie_q;
    logic [31:0] mtvec_q;
    logic [31:0] mscratch_q;
    logic [31:0] mepc_q;
    logic [31:0] mcause_q;
    logic [31:0] mtval_q;

    csr_addr_e   csr_addr;
    logic [31:0] cur_val;
    logic [31:0] wmask;
    logic [31:0] new_val;
    logic [31:0] wr_data;
    logic        write_fire;
    logic [31:0] exc_epc;
    logic [31:0] exc_tval;

    assign csr_addr = csr_addr_e'(address_i);

    // Current value and writable bits of the addressed CSR
    always_comb begin
        cur_val = '0;
        wmask   = '0;
        case (csr_addr)
            MVENDORID, MARCHID, MIMPID, MHARTID, MCONFIGPTR: begin
                cur_val = '0; // ID registers read as zero
            end
            MSTATUS: begin
                cur_val = mstatus_q;
                wmask   = MSTATUS_WMASK;
            end
            MISA: begin
                cur_val = misa_q;
                wmask   = MISA_WMASK;
            end
            MIE: begin
                cur_val = mie_q;
                wmask   = MIE_WMASK;
            end
            MTVEC: begin
                cur_val = mtvec_q;
                wmask   = ALIGN_WMASK;
            end
            MSCRATCH: begin
                cur_val = mscratch_q;
                wmask   = FULL_WMASK;
            end
            MEPC: begin
                cur_val = mepc_q;
                wmask   = ALIGN_WMASK;
            end
            MCAUSE: begin
                cur_val = mcause_q;
                wmask   = FULL_WMASK;
            end
            MTVAL: begin
                cur_val = mtval_q;
                wmask   = FULL_WMASK;
            end
            MIP:      cur_val = mip_i;            // Read-only here
            CYCLE:    cur_val = cycle_i[31:0];
            CYCLEH:   cur_val = cycle_i[63:32];
            INSTRET:  cur_val = instret_i[31:0];
            INSTRETH: cur_val = instret_i[63:32];
            default:  cur_val = '0;
        endcase
    end

    // Read-modify-write, then keep only the writable bits
    always_comb begin
        case (op_i)
            CSR_WRITE: new_val = wdata_i;
            CSR_SET:   new_val = cur_val | wdata_i;
            CSR_CLEAR: new_val = cur_val & ~wdata_i;
            default:   new_val = cur_val;
        endcase
    end

    assign wr_data    = new_val & wmask;
    assign write_fire = write_en_i && !killed_i && (op_i != CSR_NONE);

    // Return address and trap value for exceptions
    assign exc_epc  = (exc_code_i == ECALL_FROM_MMODE) ? pc_i : pc_i + 32'd4;
    assign exc_tval = (exc_code_i == ILLEGAL_INSTRUCTION) ? instr_i : pc_i;

    always_ff @(posedge clk) begin
        if (reset) begin
            mstatus_q  <= '0;
            misa_q     <= MISA_RESET;
            mie_q      <= '0;
            mtvec_q    <= '0;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mtval_q    <= '0;
        end else if (mret_i) begin
            mstatus_q[MSTATUS_MIE_BIT] <= mstatus_q[MSTATUS_MPIE_BIT];
        end else if (exception_i) begin
            mcause_q                         <= {1'b0, 26'd0, exc_code_i};
            mstatus_q[MSTATUS_MPP_LSB +: 2]  <= privilege_i;
            mstatus_q[MSTATUS_MPIE_BIT]      <= mstatus_q[MSTATUS_MIE_BIT];
            mstatus_q[MSTATUS_MIE_BIT]       <= 1'b0;
            mepc_q                           <= exc_epc & ALIGN_WMASK;
            mtval_q                          <= exc_tval;
        end else if (irq_ack_i) begin
            mcause_q                         <= {1'b1, 26'd0, irq_code_i};
            mstatus_q[MSTATUS_MPP_LSB +: 2]  <= privilege_i;
            mstatus_q[MSTATUS_MPIE_BIT]      <= mstatus_q[MSTATUS_MIE_BIT];
            mstatus_q[MSTATUS_MIE_BIT]       <= 1'b0;
            mepc_q                           <= pc_i & ALIGN_WMASK; // Interrupted pc
        end else if (write_fire) begin
            case (csr_addr)
                MSTATUS:  mstatus_q  <= wr_data;
                MISA:     misa_q     <= wr_data;
                MIE:      mie_q      <= wr_data;
                MTVEC:    mtvec_q    <= wr_data;
                MSCRATCH: mscratch_q <= wr_data;
                MEPC:     mepc_q     <= wr_data;
                MCAUSE:   mcause_q   <= wr_data;
                MTVAL:    mtval_q    <= wr_data;
                default: ; // Read-only or unsupported, ignored
            endcase
        end
    end

    assign rdata_o = (read_en_i && !killed_i) ? cur_val : '0;

    assign mtvec_o       = mtvec_q;
    assign mepc_o        = mepc_q;
    assign mie_o         = mie_q;
    assign mstatus_mie_o = mstatus_q[MSTATUS_MIE_BIT];

endmodule

/* csr_irq_arbiter.sv */
module csr_irq_arbiter
    import csr_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] irq_i,
    input  logic [31:0] mie_i,
    input  logic        mstatus_mie_i,
    input  logic        irq_ack_i,
    output logic [31:0] mip_o,
    output logic        irq_pending_o,
    output irq_code_e   irq_code_o
);

    logic [31:0] mip_q;
    logic [31:0] enabled;
    logic        take;
    irq_code_e   next_code;

    // Interrupt lines sampled once per cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            mip_q <= '0;
        end else begin
            mip_q <= irq_i;
        end
    end

    assign enabled = mie_i & mip_q;
    assign take    = mstatus_mie_i && (enabled != '0) && !irq_ack_i;

    // External first, then software, then timer
    always_comb begin
        next_code = irq_code_o;
        if (enabled[IRQ_EXT_BIT]) begin
            next_code = M_EXT_INT;
        end else if (enabled[IRQ_SW_BIT]) begin
            next_code = M_SW_INT;
        end else if (enabled[IRQ_TIM_BIT]) begin
            next_code = M_TIM_INT;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            irq_pending_o <= 1'b0;
            irq_code_o    <= M_SW_INT;
        end else begin
            irq_pending_o <= take;
            if (take) irq_code_o <= next_code; // Hold last cause otherwise
        end
    end

    assign mip_o = mip_q;

endmodule

/* csr_perf_counters.sv */
module csr_perf_counters (
    input  logic        clk,
    input  logic        reset,
    input  logic        retire_i,
    output logic [63:0] cycle_o,
    output logic [63:0] instret_o
);

    logic [63:0] cycle_q;
    logic [63:0] instret_q;

    // Free-running cycle count
    always_ff @(posedge clk) begin
        if (reset) begin
            cycle_q <= '0;
        end else begin
            cycle_q <= cycle_q + 64'd1;
        end
    end

    // Retired instructions only
    always_ff @(posedge clk) begin
        if (reset) begin
            instret_q <= '0;
        end else if (retire_i) begin
            instret_q <= instret_q + 64'd1;
        end
    end

    assign cycle_o   = cycle_q;
    assign instret_o = instret_q;

endmodule

/* csr_pkg.sv */
package csr_pkg;

    // Machine-mode CSR addresses
    typedef enum logic [11:0] {
        MVENDORID  = 12'hF11,
        MARCHID    = 12'hF12,
        MIMPID     = 12'hF13,
        MHARTID    = 12'hF14,
        MCONFIGPTR = 12'hF15,
        MSTATUS    = 12'h300,
        MISA       = 12'h301,
        MIE        = 12'h304,
        MTVEC      = 12'h305,
        MSCRATCH   = 12'h340,
        MEPC       = 12'h341,
        MCAUSE     = 12'h342,
        MTVAL      = 12'h343,
        MIP        = 12'h344,
        CYCLE      = 12'hC00,
        INSTRET    = 12'hC02,
        CYCLEH     = 12'hC80,
        INSTRETH   = 12'hC82
    } csr_addr_e;

    typedef enum logic [1:0] {
        CSR_NONE  = 2'd0,
        CSR_WRITE = 2'd1,
        CSR_SET   = 2'd2,
        CSR_CLEAR = 2'd3
    } csr_op_e;

    typedef enum logic [4:0] {
        INSTR_MISALIGNED    = 5'd0,
        INSTR_ACCESS_FAULT  = 5'd1,
        ILLEGAL_INSTRUCTION = 5'd2,
        BREAKPOINT          = 5'd3,
        LOAD_MISALIGNED     = 5'd4,
        LOAD_ACCESS_FAULT   = 5'd5,
        STORE_MISALIGNED    = 5'd6,
        STORE_ACCESS_FAULT  = 5'd7,
        ECALL_FROM_UMODE    = 5'd8,
        ECALL_FROM_SMODE    = 5'd9,
        ECALL_FROM_MMODE    = 5'd11
    } exc_code_e;

    // Interrupt cause codes, also the mip/mie bit positions
    typedef enum logic [4:0] {
        M_SW_INT  = 5'd3,
        M_TIM_INT = 5'd7,
        M_EXT_INT = 5'd11
    } irq_code_e;

    // mstatus fields
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LSB  = 11; // 2-bit MPP field

    localparam int IRQ_SW_BIT  = 3;
    localparam int IRQ_TIM_BIT = 7;
    localparam int IRQ_EXT_BIT = 11;

    // Writable bits per register
    localparam logic [31:0] MSTATUS_WMASK = 32'h007E19AA;
    localparam logic [31:0] MISA_WMASK    = 32'h3C000000;
    localparam logic [31:0] MIE_WMASK     = 32'h00000888;
    localparam logic [31:0] ALIGN_WMASK   = 32'hFFFFFFFC; // mtvec, mepc
    localparam logic [31:0] FULL_WMASK    = 32'hFFFFFFFF;

    localparam logic [31:0] MISA_RESET = 32'h40000100; // RV32I

endpackage

/* csr_unit.sv */
module csr_unit
    import csr_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    input  logic        read_en_i,
    input  logic        write_en_i,
    input  csr_op_e     op_i,
    input  logic [11:0] address_i,
    input  logic [31:0] wdata_i,
    input  logic        killed_i,
    input  logic        retire_i,
    output logic [31:0] rdata_o,

    input  logic        exception_i,
    input  logic        mret_i,
    input  exc_code_e   exc_code_i,
    input  logic [1:0]  privilege_i,
    input  logic [31:0] pc_i,
    input  logic [31:0] instr_i,

    input  logic [31:0] irq_i,
    input  logic        irq_ack_i,
    output logic        irq_pending_o,

    output logic [31:0] mtvec_o,
    output logic [31:0] mepc_o
);

    logic [31:0] mie;
    logic        mstatus_mie;
    logic [31:0] mip;
    irq_code_e   irq_code;
    logic [63:0] cycle;
    logic [63:0] instret;

    csr_file u_file (
        .clk           (clk),
        .reset         (reset),
        .read_en_i     (read_en_i),
        .write_en_i    (write_en_i),
        .op_i          (op_i),
        .address_i     (address_i),
        .wdata_i       (wdata_i),
        .killed_i      (killed_i),
        .rdata_o       (rdata_o),
        .exception_i   (exception_i),
        .mret_i        (mret_i),
        .exc_code_i    (exc_code_i),
        .privilege_i   (privilege_i),
        .pc_i          (pc_i),
        .instr_i       (instr_i),
        .irq_ack_i     (irq_ack_i),
        .mip_i         (mip),
        .irq_code_i    (irq_code),
        .cycle_i       (cycle),
        .instret_i     (instret),
        .mtvec_o       (mtvec_o),
        .mepc_o        (mepc_o),
        .mie_o         (mie),
        .mstatus_mie_o (mstatus_mie)
    );

    csr_irq_arbiter u_irq (
        .clk           (clk),
        .reset         (reset),
        .irq_i         (irq_i),
        .mie_i         (mie),
        .mstatus_mie_i (mstatus_mie),
        .irq_ack_i     (irq_ack_i),
        .mip_o         (mip),
        .irq_pending_o (irq_pending_o),
        .irq_code_o    (irq_code)
    );

    csr_perf_counters u_perf (
        .clk       (clk),
        .reset     (reset),
        .retire_i  (retire_i),
        .cycle_o   (cycle),
        .instret_o (instret)
    );

endmodule

/* csr_unit_assertions.sv */
module csr_unit_assertions (
    input logic        clk,
    input logic        reset,
    input logic        irq_ack_i,
    input logic        irq_pending_i,
    input logic [31:0] mepc_i,
    input logic [63:0] cycle_i
);

    // Pending flag clears one cycle after reset
    a_pending_after_reset: assert property (
        @(posedge clk) reset |=> !irq_pending_i
    ) else $error("irq_pending_o high in the cycle after reset");

    a_pending_after_ack: assert property (
        @(posedge clk) irq_ack_i |=> !irq_pending_i
    ) else $error("irq_pending_o high in the cycle after irq_ack_i");

    a_mepc_aligned: assert property (
        @(posedge clk) disable iff (reset) mepc_i[1:0] == 2'b00
    ) else $error("mepc_o low bits not zero");

    a_cycle_step: assert property (
        @(posedge clk) disable iff (reset) 1'b1 |=> cycle_i == $past(cycle_i) + 64'd1
    ) else $error("cycle counter did not step by one");

endmodule

/* project.f */
csr_pkg.sv
csr_perf_counters.sv
csr_irq_arbiter.sv
csr_file.sv
csr_unit.sv
csr_unit_assertions.sv
csr_checker.sv
tb_csr_unit.sv

/* tb_csr_unit.sv */
module tb_csr_unit;
    import csr_pkg::*;

    localparam logic [1:0] NO_CHECK  = 2'd0;
    localparam logic [1:0] EXACT     = 2'd1;
    localparam logic [1:0] CAPTURE   = 2'd2;
    localparam logic [1:0] DELTA     = 2'd3;
    localparam logic [1:0] PRIV      = 2'b11;
    localparam logic [1:0] USER_MODE = 2'b00;
    localparam int         WAIT_MAX  = 16;

    typedef struct packed {
        logic        we;
        csr_op_e     op;
        logic [11:0] addr;
        logic [31:0] wdata;
        logic        killed;
        logic        retire;
        logic        exc;
        logic        mret;
        exc_code_e   code;
        logic [1:0]  priv;
        logic [31:0] pc;
        logic [31:0] instr;
        logic [31:0] irq;
        logic        ack;
        logic [1:0]  mode;
        logic [31:0] exp;
        logic        exp_pend;
    } row_t;

    logic clk, reset, read_en, write_en, killed, retire, exception, mret, irq_ack;
    csr_op_e     op;
    exc_code_e   exc_code;
    logic [11:0] address;
    logic [1:0]  privilege;
    logic [31:0] wdata, pc, instr, irq, rdata, mtvec, mepc;
    logic        irq_pending;
    logic [1:0]  chk_mode;
    logic [31:0] chk_exp;
    logic        chk_pend;
    int          row_idx, pass_count, fail_count;

    row_t        r, idle;
    row_t        tbl[$];
    logic [31:0] m_status, m_ie, m_scratch, m_tvec, m_isa;
    int          n_ret, n_seg1, waited;
    logic        timed_out;

    csr_unit uut (
        .clk(clk), .reset(reset), .read_en_i(read_en), .write_en_i(write_en), .op_i(op),
        .address_i(address), .wdata_i(wdata), .killed_i(killed), .retire_i(retire),
        .rdata_o(rdata), .exception_i(exception), .mret_i(mret), .exc_code_i(exc_code),
        .privilege_i(privilege), .pc_i(pc), .instr_i(instr), .irq_i(irq),
        .irq_ack_i(irq_ack), .irq_pending_o(irq_pending), .mtvec_o(mtvec), .mepc_o(mepc)
    );

    csr_checker u_checker (
        .clk(clk), .rdata_i(rdata), .irq_pending_i(irq_pending), .addr_i(address),
        .mtvec_i(mtvec), .mepc_i(mepc), .mode_i(chk_mode),
        .exp_rdata_i(chk_exp), .exp_pending_i(chk_pend), .row_i(row_idx),
        .pass_count_o(pass_count), .fail_count_o(fail_count)
    );

    bind csr_unit csr_unit_assertions u_assertions (
        .clk(clk), .reset(reset), .irq_ack_i(irq_ack_i), .irq_pending_i(irq_pending_o),
        .mepc_i(mepc_o), .cycle_i(cycle)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] apply_op(input csr_op_e o, input logic [31:0] old,
                                             input logic [31:0] d, input logic [31:0] mask);
        case (o)
            CSR_WRITE: return d & mask;
            CSR_SET:   return (old | d) & mask;
            CSR_CLEAR: return (old & ~d) & mask;
            default:   return old;
        endcase
    endfunction

    // Trap entry: MPP from privilege, MIE saved into MPIE and cleared
    function automatic logic [31:0] trap_status(input logic [31:0] st, input logic [1:0] p);
        logic [31:0] nx;
        nx = st;
        nx[MSTATUS_MPP_LSB +: 2] = p;
        nx[MSTATUS_MPIE_BIT]     = st[MSTATUS_MIE_BIT];
        nx[MSTATUS_MIE_BIT]      = 1'b0;
        return nx;
    endfunction

    task automatic add(input logic we, input csr_op_e o, input logic [11:0] a,
                       input logic [31:0] d, input logic [1:0] mode, input logic [31:0] e);
        logic [31:0] lines;
        r.we    = we;
        r.op    = o;
        r.addr  = a;
        r.wdata = d;
        r.mode  = mode;
        r.exp   = e;
        if (r.retire) n_ret++;
        tbl.push_back(r);
        lines = r.irq; // Interrupt lines stay up across rows
        r     = '0;
        r.irq = lines;
    endtask

    task automatic rmw(input csr_op_e o, input logic [11:0] a, input logic [31:0] mask,
                       inout logic [31:0] model);
        logic [31:0] d;
        d        = $urandom;
        model    = apply_op(o, model, d, mask);
        r.retire = d[0];
        add(1'b1, o, a, d, EXACT, model);
    endtask

    task automatic build_table();
        csr_addr_e   zero_addrs [16] = '{MSTATUS, MIE, MTVEC, MSCRATCH, MEPC, MCAUSE, MTVAL,
            MIP, MVENDORID, MARCHID, MIMPID, MHARTID, MCONFIGPTR, CYCLEH, INSTRET, INSTRETH};
        csr_op_e     ops [3] = '{CSR_WRITE, CSR_SET, CSR_CLEAR};
        logic [31:0] pc_v, ins, d;
        int          cap_idx;
        m_status = '0;
        m_ie = '0;
        m_scratch = '0;
        m_tvec = '0;
        m_isa = MISA_RESET;
        n_ret = 0;
        r = '0;
        add(1'b0, CSR_NONE, MISA, '0, EXACT, MISA_RESET);
        foreach (zero_addrs[k]) add(1'b0, CSR_NONE, zero_addrs[k], '0, EXACT, '0);
        cap_idx = tbl.size();
        add(1'b0, CSR_NONE, CYCLE, '0, CAPTURE, '0);
        foreach (ops[k]) begin
            rmw(ops[k], MSCRATCH, FULL_WMASK, m_scratch);
            rmw(ops[k], MSTATUS, MSTATUS_WMASK, m_status);
            rmw(ops[k], MIE, MIE_WMASK, m_ie);
            rmw(ops[k], MTVEC, ALIGN_WMASK, m_tvec);
            rmw(ops[k], MISA, MISA_WMASK, m_isa);
        end
        d = $urandom;
        add(1'b1, CSR_WRITE, MHARTID, d, EXACT, '0); // Read-only targets
        add(1'b1, CSR_WRITE, MIP, d, EXACT, '0);
        add(1'b1, CSR_WRITE, CYCLEH, d, EXACT, '0);
        r.killed = 1'b1;
        add(1'b1, CSR_WRITE, MSCRATCH, d, EXACT, '0);
        add(1'b0, CSR_NONE, MSCRATCH, '0, EXACT, m_scratch);
        add(1'b0, CSR_NONE, INSTRET, '0, EXACT, n_ret);
        add(1'b0, CSR_NONE, CYCLE, '0, DELTA, tbl.size() - cap_idx);
        // Illegal instruction, then mret
        m_status = apply_op(CSR_WRITE, m_status, 32'h8, MSTATUS_WMASK);
        add(1'b1, CSR_WRITE, MSTATUS, 32'h8, EXACT, m_status);
        pc_v = $urandom & ALIGN_WMASK;
        ins  = $urandom;
        r.exc = 1'b1;
        r.code = ILLEGAL_INSTRUCTION;
        r.priv = PRIV;
        r.pc = pc_v;
        r.instr = ins;
        m_status = trap_status(m_status, PRIV);
        add(1'b0, CSR_NONE, MCAUSE, '0, EXACT, 32'(ILLEGAL_INSTRUCTION));
        add(1'b0, CSR_NONE, MEPC, '0, EXACT, pc_v + 32'd4);
        add(1'b0, CSR_NONE, MTVAL, '0, EXACT, ins);
        add(1'b0, CSR_NONE, MSTATUS, '0, EXACT, m_status);
        r.mret = 1'b1;
        m_status[MSTATUS_MIE_BIT] = m_status[MSTATUS_MPIE_BIT];
        add(1'b0, CSR_NONE, MSTATUS, '0, EXACT, m_status);
        // Ecall from M-mode keeps the pc as return address
        pc_v = $urandom & ALIGN_WMASK;
        r.exc = 1'b1;
        r.code = ECALL_FROM_MMODE;
        r.priv = PRIV;
        r.pc = pc_v;
        r.instr = $urandom;
        m_status = trap_status(m_status, PRIV);
        add(1'b0, CSR_NONE, MCAUSE, '0, EXACT, 32'(ECALL_FROM_MMODE));
        add(1'b0, CSR_NONE, MEPC, '0, EXACT, pc_v);
        add(1'b0, CSR_NONE, MTVAL, '0, EXACT, pc_v);
        add(1'b0, CSR_NONE, MSTATUS, '0, EXACT, m_status);
        // Lines up with global MIE clear
        m_ie = apply_op(CSR_WRITE, m_ie, FULL_WMASK, MIE_WMASK);
        add(1'b1, CSR_WRITE, MIE, FULL_WMASK, EXACT, m_ie);
        r.irq = (32'd1 << IRQ_SW_BIT) | (32'd1 << IRQ_TIM_BIT) | (32'd1 << IRQ_EXT_BIT);
        add(1'b0, CSR_NONE, MIP, '0, EXACT, 32'h888);
        add(1'b0, CSR_NONE, MIP, '0, EXACT, 32'h888);
        add(1'b0, CSR_NONE, MIP, '0, EXACT, 32'h888);
        m_status = apply_op(CSR_SET, m_status, 32'h8, MSTATUS_WMASK);
        add(1'b1, CSR_SET, MSTATUS, 32'h8, EXACT, m_status);
        n_seg1 = tbl.size();
        // Acknowledge after pending is seen, taken from user mode
        pc_v = $urandom & ALIGN_WMASK;
        r.ack = 1'b1;
        r.priv = USER_MODE;
        r.pc = pc_v;
        m_status = trap_status(m_status, USER_MODE);
        add(1'b0, CSR_NONE, MCAUSE, '0, EXACT, {1'b1, 26'd0, M_EXT_INT});
        add(1'b0, CSR_NONE, MEPC, '0, EXACT, pc_v);
        r.irq = '0;
        add(1'b0, CSR_NONE, MSTATUS, '0, EXACT, m_status);
        add(1'b0, CSR_NONE, MIP, '0, EXACT, '0);
        add(1'b0, CSR_NONE, INSTRET, '0, EXACT, n_ret);
    endtask

    task automatic drive_row(input row_t x, input int idx);
        @(negedge clk);
        read_en   <= (x.mode != NO_CHECK);
        write_en  <= x.we;
        op        <= x.op;
        address   <= x.addr;
        wdata     <= x.wdata;
        killed    <= x.killed;
        retire    <= x.retire;
        exception <= x.exc;
        mret      <= x.mret;
        exc_code  <= x.code;
        privilege <= x.priv;
        pc        <= x.pc;
        instr     <= x.instr;
        irq       <= x.irq;
        irq_ack   <= x.ack;
        chk_mode  <= x.mode;
        chk_exp   <= x.exp;
        chk_pend  <= x.exp_pend;
        row_idx   <= idx;
    endtask

    initial begin
        void'($urandom(32'h33d4a450));
        reset = 1'b1;
        read_en = 1'b0;
        write_en = 1'b0;
        op = CSR_NONE;
        address = '0;
        wdata = '0;
        killed = 1'b0;
        retire = 1'b0;
        exception = 1'b0;
        mret = 1'b0;
        exc_code = INSTR_MISALIGNED;
        privilege = PRIV;
        pc = '0;
        instr = '0;
        irq = '0;
        irq_ack = 1'b0;
        chk_mode = NO_CHECK;
        chk_exp = '0;
        chk_pend = 1'b0;
        row_idx = 0;
        timed_out = 1'b0;
        build_table();
        repeat (2) @(negedge clk);
        reset <= 1'b0;
        for (int i = 0; i < n_seg1; i++) drive_row(tbl[i], i);
        idle = '0;
        idle.irq = tbl[n_seg1 - 1].irq;
        drive_row(idle, -1);
        waited = 0;
        while (irq_pending !== 1'b1 && waited < WAIT_MAX) begin
            drive_row(idle, -1);
            waited++;
        end
        if (irq_pending !== 1'b1) begin
            timed_out = 1'b1;
            $display("irq_pending_o did not rise within %0d cycles", WAIT_MAX);
        end else begin
            for (int i = n_seg1; i < tbl.size(); i++) drive_row(tbl[i], i);
        end
        idle = '0;
        drive_row(idle, -1);
        drive_row(idle, -1);
        @(posedge clk);
        $display("Checks: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0 && !timed_out) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #50000;
        $display("Run time limit reached before the test ended");
        $display("Simulation failed");
        $finish;
    end

endmodule
